// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_mul_unit
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Test failed" $(LOG) || [ $$status -ne 0 ]; then \
		echo "FAIL"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== booth_encoder.sv ====
// Operands load only on start; partial products and adj update on every clock regardless
`include "mul_macros.svh"

module booth_encoder (
	input  logic CLK,
	input  logic nRST,
	input  logic start,
	input  logic [`MUL_XLEN-1:0] a,
	input  logic [`MUL_XLEN-1:0] b,
	input  mul_pkg::sign_sel_t sign,
	output mul_pkg::pp_bundle_t pp,
	output mul_pkg::adj_info_t adj
);

	logic [`MUL_XLEN-1:0] a_q;
	logic [`MUL_XLEN-1:0] b_q;
	mul_pkg::sign_sel_t sign_q;
	logic [`MUL_XLEN-1:0] mcand;
	logic [`MUL_XLEN-1:0] mplier;
	logic [`MUL_XLEN:0] recode;
	logic [`MUL_PROD_W-1:0] pos1;
	logic [`MUL_PROD_W-1:0] pos2;
	logic [`MUL_PROD_W-1:0] neg1;
	logic [`MUL_PROD_W-1:0] neg2;
	mul_pkg::pp_bundle_t pp_d;
	mul_pkg::adj_info_t adj_d;

	// Operand capture
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			a_q <= '0;
			b_q <= '0;
			sign_q <= '0;
		end else if (start) begin
			a_q <= a;
			b_q <= b;
			sign_q <= sign;
		end
	end

	// Magnitudes of signed operands
	assign mcand = (sign_q.rs1_signed && a_q[`MUL_XLEN-1]) ? -a_q : a_q;
	assign mplier = (sign_q.rs2_signed && b_q[`MUL_XLEN-1]) ? -b_q : b_q;

	// Booth reads mplier as signed, so a set top bit needs +2^32*M later
	assign adj_d.negate = (sign_q.rs1_signed & a_q[`MUL_XLEN-1]) ^
		(sign_q.rs2_signed & b_q[`MUL_XLEN-1]);
	assign adj_d.hi_fix = mplier[`MUL_XLEN-1];
	assign adj_d.mcand_abs = mcand;

	assign recode = {mplier, 1'b0};
	assign pos1 = {{(`MUL_PROD_W-`MUL_XLEN){1'b0}}, mcand};
	assign pos2 = pos1 << 1;
	assign neg1 = -pos1;
	assign neg2 = -pos2;

	// Radix-4 recoding on overlapping triples
	always_comb begin
		logic [`MUL_PROD_W-1:0] mult;
		for (int i = 0; i < `MUL_PP_COUNT; i++) begin
			case (recode[2*i +: 3])
				3'b001, 3'b010: mult = pos1;
				3'b011: mult = pos2;
				3'b100: mult = neg2;
				3'b101, 3'b110: mult = neg1;
				default: mult = '0;
			endcase
			pp_d.part[i] = mult << (2 * i);
		end
	end

	// Stage register ahead of the tree
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			pp <= '0;
			adj <= '0;
		end else begin
			pp <= pp_d;
			adj <= adj_d;
		end
	end

	a_pp_known: assert property (@(posedge CLK) disable iff (!nRST) !$isunknown(pp));

endmodule

// ==== files.f ====
+incdir+.
mul_pkg.sv
mul_csa.sv
booth_encoder.sv
wallace_tree.sv
product_adjust.sv
mul_unit.sv
tb_mul_unit.sv

// ==== mul_csa.sv ====
// Carry out of the top bit is dropped, so results are modulo 2^W
module mul_csa #(
	parameter int W = 64
) (
	input  logic [W-1:0] x,
	input  logic [W-1:0] y,
	input  logic [W-1:0] z,
	output logic [W-1:0] sum,
	output logic [W-1:0] cout
);

	logic [W-1:0] maj;

	// Per-bit full adder
	assign sum = x ^ y ^ z;
	assign maj = (x & y) | (x & z) | (y & z);

	// Carry weight is one bit higher
	assign cout = {maj[W-2:0], 1'b0};

endmodule

// ==== mul_macros.svh ====
// Widths are fixed for RV32; the tree wiring assumes exactly sixteen partial products
`ifndef MUL_MACROS_SVH
`define MUL_MACROS_SVH

// Operand width
`define MUL_XLEN 32

// Full product width
`define MUL_PROD_W 64

// Radix-4 Booth gives one partial product per two multiplier bits
`define MUL_PP_COUNT 16

// Vectors held in the mid-tree register
// six layer-2 outputs, the spare partial product and the spare layer-1 sum
`define MUL_PP_GROUPS 8

`endif

// ==== mul_pkg.sv ====
// Types for the pipelined multiplier; field order of mul_req_t is a, b, op from MSB down
`include "mul_macros.svh"

package mul_pkg;

	// M extension multiply operations
	typedef enum logic [1:0] {
		MUL    = 2'b00,
		MULH   = 2'b01,
		MULHSU = 2'b10,
		MULHU  = 2'b11
	} mul_op_t;

	typedef struct packed {
		logic rs1_signed;
		logic rs2_signed;
	} sign_sel_t;

	typedef struct packed {
		logic [`MUL_XLEN-1:0] a;
		logic [`MUL_XLEN-1:0] b;
		mul_op_t op;
	} mul_req_t;

	// Index i holds the multiple for multiplier bits 2i+1..2i, already shifted
	typedef struct packed {
		logic [`MUL_PP_COUNT-1:0][`MUL_PROD_W-1:0] part;
	} pp_bundle_t;

	// Final-stage corrections carried beside the data
	typedef struct packed {
		logic negate;
		logic hi_fix;
		logic [`MUL_XLEN-1:0] mcand_abs;
	} adj_info_t;

	typedef struct packed {
		logic [`MUL_PROD_W-1:0] sum;
		logic [`MUL_PROD_W-1:0] carry;
	} tree_out_t;

endpackage

// ==== mul_unit.sv ====
// Fixed 3-cycle latency, no stall; the receiver must take result in the cycle finished is high
`include "mul_macros.svh"

module mul_unit (
	input  logic CLK,
	input  logic nRST,
	input  logic start,
	input  mul_pkg::mul_req_t req,
	output logic finished,
	output logic next_finished,
	output logic [`MUL_XLEN-1:0] result
);

	mul_pkg::sign_sel_t sign;
	logic hi_sel;
	logic [2:0] start_sr;
	logic [2:0] sel_sr;
	mul_pkg::pp_bundle_t pp;
	mul_pkg::adj_info_t adj_s1;
	mul_pkg::adj_info_t adj_s2;
	mul_pkg::tree_out_t tree;
	logic [`MUL_PROD_W-1:0] product;

	// Operand signedness per operation
	always_comb begin
		case (req.op)
			mul_pkg::MULHSU: sign = '{rs1_signed: 1'b1, rs2_signed: 1'b0};
			mul_pkg::MULHU: sign = '{rs1_signed: 1'b0, rs2_signed: 1'b0};
			// MUL low word does not depend on signedness
			default: sign = '{rs1_signed: 1'b1, rs2_signed: 1'b1};
		endcase
	end

	assign hi_sel = (req.op != mul_pkg::MUL);

	// Strobe and word-select tracking alongside the data
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			start_sr <= '0;
			sel_sr <= '0;
		end else begin
			start_sr <= {start_sr[1:0], start};
			sel_sr <= {sel_sr[1:0], hi_sel};
		end
	end

	assign next_finished = start_sr[1];
	assign finished = start_sr[2];

	booth_encoder u_booth_encoder (
		.CLK(CLK), .nRST(nRST), .start(start), .a(req.a), .b(req.b),
		.sign(sign), .pp(pp), .adj(adj_s1)
	);

	wallace_tree u_wallace_tree (
		.CLK(CLK), .nRST(nRST), .pp(pp), .adj_in(adj_s1),
		.tree(tree), .adj_out(adj_s2)
	);

	product_adjust u_product_adjust (.tree(tree), .adj(adj_s2), .product(product));

	assign result = sel_sr[2] ? product[`MUL_PROD_W-1:`MUL_XLEN] : product[`MUL_XLEN-1:0];

	a_finish_latency: assert property (@(posedge CLK) disable iff (!nRST)
		finished == $past(start, 3));

endmodule

// ==== product_adjust.sv ====
// Purely combinational; product is only meaningful in the cycle the top level marks finished
`include "mul_macros.svh"

module product_adjust (
	input  mul_pkg::tree_out_t tree,
	input  mul_pkg::adj_info_t adj,
	output logic [`MUL_PROD_W-1:0] product
);

	logic [`MUL_PROD_W-1:0] raw;
	logic [`MUL_PROD_W-1:0] fix;
	logic [`MUL_PROD_W-1:0] mag;

	// Carry-propagate add of the redundant form
	assign raw = tree.sum + tree.carry;

	// Booth saw the multiplier as signed
	// so add back 2^32 * |M| when its top bit was set
	assign fix = adj.hi_fix ? {adj.mcand_abs, {`MUL_XLEN{1'b0}}} : '0;

	// Magnitude of the true product, modulo 2^64
	assign mag = raw + fix;

	// Restore sign when exactly one operand was negative
	assign product = adj.negate ? -mag : mag;

endmodule

// ==== tb_mul_unit.sv ====
// Self-checking testbench for mul_unit; assumes the fixed 3-cycle latency and no back-pressure
`include "mul_macros.svh"

module tb_mul_unit;

	localparam logic [31:0] SEED = 32'h13f49ac0;
	localparam int RAND_CYCLES = 600;
	localparam int DIRECTED_REQS = 8;
	localparam int BURST_LEN = 16;
	localparam int TOTAL_REQS = RAND_CYCLES + DIRECTED_REQS + BURST_LEN;
	localparam int WATCHDOG_TIME = (TOTAL_REQS + 20) * 4 * 4;

	typedef struct packed {
		logic [`MUL_XLEN-1:0] value;
		logic [31:0] issue;
		mul_pkg::mul_op_t op;
	} expect_t;

	logic CLK;
	logic nRST;
	logic start;
	mul_pkg::mul_req_t req;
	logic finished;
	logic next_finished;
	logic [`MUL_XLEN-1:0] result;

	expect_t exp_q [$];
	logic [3:0] hist;
	logic [31:0] cycle;
	int err_value;
	int err_strobe;
	int err_order;
	int n_issued;
	int unsigned seed_sink;

	mul_unit u_mul_unit (
		.CLK(CLK),
		.nRST(nRST),
		.start(start),
		.req(req),
		.finished(finished),
		.next_finished(next_finished),
		.result(result)
	);

	always #2 CLK = ~CLK;

	// Reference: extend per operation, full 64-bit multiply, pick the word
	function automatic logic [`MUL_XLEN-1:0] model_result(input mul_pkg::mul_op_t op,
			input logic [`MUL_XLEN-1:0] a, input logic [`MUL_XLEN-1:0] b);
		logic [`MUL_PROD_W-1:0] xa;
		logic [`MUL_PROD_W-1:0] xb;
		logic [`MUL_PROD_W-1:0] p;
		xa = (op != mul_pkg::MULHU) ? {{`MUL_XLEN{a[`MUL_XLEN-1]}}, a} : {{`MUL_XLEN{1'b0}}, a};
		xb = (op == mul_pkg::MUL || op == mul_pkg::MULH) ?
			{{`MUL_XLEN{b[`MUL_XLEN-1]}}, b} : {{`MUL_XLEN{1'b0}}, b};
		p = xa * xb;
		if (op == mul_pkg::MUL)
			return p[`MUL_XLEN-1:0];
		return p[`MUL_PROD_W-1:`MUL_XLEN];
	endfunction

	// Mostly random, one in eight from the corner set
	function automatic logic [`MUL_XLEN-1:0] pick_operand();
		logic [31:0] r;
		r = $urandom;
		if (r[2:0] != 3'd0)
			return $urandom;
		case (r[5:3] % 3'd5)
			3'd0: return 32'h0000_0000;
			3'd1: return 32'h0000_0001;
			3'd2: return 32'hffff_ffff;
			3'd3: return 32'h8000_0000;
			default: return 32'h7fff_ffff;
		endcase
	endfunction

	// One clock: drive after the edge, check at the falling edge
	task automatic run_cycle(input logic go, input mul_pkg::mul_op_t op,
			input logic [`MUL_XLEN-1:0] a, input logic [`MUL_XLEN-1:0] b);
		expect_t ent;
		@(posedge CLK);
		cycle = cycle + 32'd1;
		#1;
		start = go;
		req = '{a: a, b: b, op: op};
		if (go) begin
			ent.value = model_result(op, a, b);
			ent.issue = cycle;
			ent.op = op;
			exp_q.push_back(ent);
			n_issued++;
		end
		hist = {hist[2:0], go};
		@(negedge CLK);
		assert (finished === hist[3]) else begin
			err_strobe++;
			$display("FAILED %0t: finished is %b, expected %b", $time, finished, hist[3]);
		end
		assert (next_finished === hist[2]) else begin
			err_strobe++;
			$display("FAILED %0t: next_finished is %b, expected %b", $time,
				next_finished, hist[2]);
		end
		if (finished === 1'b1 && exp_q.size() == 0) begin
			err_order++;
			$display("Result strobe seen at time %0t with no request outstanding", $time);
		end else if (finished === 1'b1) begin
			ent = exp_q.pop_front();
			assert (ent.issue + 32'd3 == cycle) else begin
				err_order++;
				$display("FAILED %0t: result for cycle %0d arrived in cycle %0d", $time,
					ent.issue, cycle);
			end
			assert (result === ent.value) else begin
				err_value++;
				$display("FAILED %0t: op %s result %h, expected %h", $time,
					ent.op.name(), result, ent.value);
			end
		end
	endtask

	task automatic idle_cycle();
		run_cycle(1'b0, mul_pkg::MUL, $urandom, $urandom);
	endtask

	task automatic random_cycle();
		logic [31:0] r;
		r = $urandom;
		run_cycle(r[2:0] < 3'd5, mul_pkg::mul_op_t'(r[4:3]), pick_operand(), pick_operand());
	endtask

	initial begin
		#(WATCHDOG_TIME);
		$display("Watchdog expired before the run finished");
		$display("Errors: value %0d, strobe %0d, order %0d", err_value, err_strobe, err_order);
		$display("Test failed");
		$finish;
	end

	initial begin
		CLK = 1'b0;
		nRST = 1'b0;
		start = 1'b0;
		req = '0;
		hist = '0;
		cycle = '0;
		err_value = 0;
		err_strobe = 0;
		err_order = 0;
		n_issued = 0;
		seed_sink = $urandom(SEED);

		repeat (5) @(posedge CLK);
		#1;
		nRST = 1'b1;

		// Quiet period, strobes must stay low
		repeat (4) idle_cycle();

		repeat (RAND_CYCLES) random_cycle();

		// Sign corners, back to back
		run_cycle(1'b1, mul_pkg::MULH, 32'hffff_fff9, 32'hffff_fffd);
		run_cycle(1'b1, mul_pkg::MULH, 32'h8000_0000, 32'h8000_0000);
		run_cycle(1'b1, mul_pkg::MULH, 32'h8000_0000, 32'h7fff_ffff);
		run_cycle(1'b1, mul_pkg::MULHSU, 32'hffff_0000, 32'h8000_0001);
		run_cycle(1'b1, mul_pkg::MULHSU, 32'h8000_0000, 32'hffff_ffff);
		run_cycle(1'b1, mul_pkg::MULHU, 32'hffff_ffff, 32'hffff_ffff);
		run_cycle(1'b1, mul_pkg::MULHU, 32'h8000_0000, 32'h8000_0000);
		run_cycle(1'b1, mul_pkg::MUL, 32'h8000_0000, 32'hffff_ffff);
		repeat (3) idle_cycle();

		// Long burst keeps three requests in flight
		for (int i = 0; i < BURST_LEN; i++)
			run_cycle(1'b1, mul_pkg::mul_op_t'(i[1:0]), pick_operand(), pick_operand());

		for (int i = 0; i < 10 && exp_q.size() != 0; i++)
			idle_cycle();
		repeat (3) idle_cycle();

		if (exp_q.size() != 0) begin
			$display("Results never returned for %0d requests", exp_q.size());
			err_order += exp_q.size();
		end

		$display("Requests %0d. Errors: value %0d, strobe %0d, order %0d", n_issued,
			err_value, err_strobe, err_order);
		if (err_value + err_strobe + err_order == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== wallace_tree.sv ====
// Fixed shape for sixteen partial products; tree output is combinational from the mid register
`include "mul_macros.svh"

module wallace_tree (
	input  logic CLK,
	input  logic nRST,
	input  mul_pkg::pp_bundle_t pp,
	input  mul_pkg::adj_info_t adj_in,
	output mul_pkg::tree_out_t tree,
	output mul_pkg::adj_info_t adj_out
);

	logic [`MUL_PROD_W-1:0] s [0:13];
	logic [`MUL_PROD_W-1:0] c [0:13];
	logic [`MUL_PP_GROUPS-1:0][`MUL_PROD_W-1:0] mid_d;
	logic [`MUL_PP_GROUPS-1:0][`MUL_PROD_W-1:0] mid_q;
	logic [`MUL_PROD_W-1:0] pp_total;

	// Layer 1 reduces partial products 0..14 in groups of three
	for (genvar k = 0; k < 5; k++) begin : g_layer1
		mul_csa #(.W(`MUL_PROD_W)) u_csa (
			.x(pp.part[3*k]),
			.y(pp.part[3*k+1]),
			.z(pp.part[3*k+2]),
			.sum(s[k]),
			.cout(c[k])
		);
	end

	// Layer 2 while s4 passes through
	mul_csa #(.W(`MUL_PROD_W)) u_csa5 (.x(c[0]), .y(s[0]), .z(c[1]), .sum(s[5]), .cout(c[5]));
	mul_csa #(.W(`MUL_PROD_W)) u_csa6 (.x(s[1]), .y(c[2]), .z(s[2]), .sum(s[6]), .cout(c[6]));
	mul_csa #(.W(`MUL_PROD_W)) u_csa7 (.x(c[3]), .y(s[3]), .z(c[4]), .sum(s[7]), .cout(c[7]));

	// Slots 0..7 hold s5 c5 s6 c6 s7 c7 pp15 s4
	assign mid_d = {s[4], pp.part[`MUL_PP_COUNT-1], c[7], s[7], c[6], s[6], c[5], s[5]};

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			mid_q <= '0;
			adj_out <= '0;
		end else begin
			mid_q <= mid_d;
			adj_out <= adj_in;
		end
	end

	// Layer 3
	mul_csa #(.W(`MUL_PROD_W)) u_csa8 (
		.x(mid_q[1]), .y(mid_q[0]), .z(mid_q[3]), .sum(s[8]), .cout(c[8])
	);
	mul_csa #(.W(`MUL_PROD_W)) u_csa9 (
		.x(mid_q[2]), .y(mid_q[5]), .z(mid_q[4]), .sum(s[9]), .cout(c[9])
	);

	// Layer 4 picks up the two leftovers
	mul_csa #(.W(`MUL_PROD_W)) u_csa10 (
		.x(c[8]), .y(s[8]), .z(c[9]), .sum(s[10]), .cout(c[10])
	);
	mul_csa #(.W(`MUL_PROD_W)) u_csa11 (
		.x(s[9]), .y(mid_q[6]), .z(mid_q[7]), .sum(s[11]), .cout(c[11])
	);

	// Layers 5 and 6
	mul_csa #(.W(`MUL_PROD_W)) u_csa12 (
		.x(c[10]), .y(s[10]), .z(c[11]), .sum(s[12]), .cout(c[12])
	);
	mul_csa #(.W(`MUL_PROD_W)) u_csa13 (
		.x(c[12]), .y(s[12]), .z(s[11]), .sum(s[13]), .cout(c[13])
	);

	assign tree.sum = s[13];
	assign tree.carry = c[13];

	// Plain modulo 2^64 sum of the incoming partial products
	always_comb begin
		pp_total = '0;
		for (int i = 0; i < `MUL_PP_COUNT; i++)
			pp_total = pp_total + pp.part[i];
	end

	// Whole tree including the mid register must preserve the total
	a_tree_sum: assert property (@(posedge CLK) disable iff (!nRST)
		tree.sum + tree.carry == $past(pp_total));

endmodule
